// File: hdl/isa_pkg.sv
package isa_pkg;

	typedef logic [15:0] word_t;    // data, instruction or word address
	typedef logic [1:0]  reg_idx_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [5:0]  func_t;

	localparam opcode_t OP_BNE = 4'd0;
	localparam opcode_t OP_BEQ = 4'd1;
	localparam opcode_t OP_BGZ = 4'd2;
	localparam opcode_t OP_BLZ = 4'd3;
	localparam opcode_t OP_ADI = 4'd4;
	localparam opcode_t OP_ORI = 4'd5;
	localparam opcode_t OP_LHI = 4'd6;
	localparam opcode_t OP_LWD = 4'd7;
	localparam opcode_t OP_SWD = 4'd8;
	localparam opcode_t OP_JMP = 4'd9;
	localparam opcode_t OP_JAL = 4'd10;
	localparam opcode_t OP_ALU = 4'd15;   // r-type, selected by func

	localparam func_t FUNC_ADD = 6'd0;
	localparam func_t FUNC_SUB = 6'd1;
	localparam func_t FUNC_AND = 6'd2;
	localparam func_t FUNC_ORR = 6'd3;
	localparam func_t FUNC_NOT = 6'd4;
	localparam func_t FUNC_TCP = 6'd5;
	localparam func_t FUNC_SHL = 6'd6;
	localparam func_t FUNC_SHR = 6'd7;
	localparam func_t FUNC_JPR = 6'd25;
	localparam func_t FUNC_JRL = 6'd26;
	localparam func_t FUNC_WWD = 6'd28;
	localparam func_t FUNC_HLT = 6'd29;

	// instruction field positions
	localparam int OP_MSB = 15;
	localparam int OP_LSB = 12;
	localparam int RS_MSB = 11;
	localparam int RS_LSB = 10;
	localparam int RT_MSB = 9;
	localparam int RT_LSB = 8;
	localparam int RD_MSB = 7;
	localparam int RD_LSB = 6;
	localparam int FUNC_W = 6;
	localparam int IMM_W  = 8;
	localparam int TGT_W  = 12;

endpackage

// File: hdl/cpu_pkg.sv
package cpu_pkg;

	typedef logic [3:0] alu_func_t;
	typedef logic [1:0] pc_src_t;
	typedef logic [1:0] reg_dest_t;
	typedef logic [1:0] reg_src_t;
	typedef logic [1:0] branch_type_t;

	// 0..7 line up with the r-type function codes
	localparam alu_func_t ALU_ADD = 4'd0;
	localparam alu_func_t ALU_SUB = 4'd1;
	localparam alu_func_t ALU_AND = 4'd2;
	localparam alu_func_t ALU_ORR = 4'd3;
	localparam alu_func_t ALU_NOT = 4'd4;
	localparam alu_func_t ALU_TCP = 4'd5;
	localparam alu_func_t ALU_SHL = 4'd6;
	localparam alu_func_t ALU_SHR = 4'd7;
	localparam alu_func_t ALU_ID1 = 4'd8;   // pass operand a
	localparam alu_func_t ALU_ID2 = 4'd9;   // pass operand b
	localparam alu_func_t ALU_BXX = 4'd10;  // branch compare

	localparam pc_src_t PC_BRANCH = 2'd0;
	localparam pc_src_t PC_JUMP   = 2'd1;
	localparam pc_src_t PC_REG    = 2'd2;

	localparam reg_dest_t DEST_RD = 2'd0;
	localparam reg_dest_t DEST_RT = 2'd1;
	localparam reg_dest_t DEST_R2 = 2'd2;   // link register

	localparam reg_src_t SRC_ALU = 2'd0;
	localparam reg_src_t SRC_MEM = 2'd1;
	localparam reg_src_t SRC_PC1 = 2'd2;

	// same as opcode[1:0] of the branches
	localparam branch_type_t BR_NE = 2'd0;
	localparam branch_type_t BR_EQ = 2'd1;
	localparam branch_type_t BR_GZ = 2'd2;
	localparam branch_type_t BR_LZ = 2'd3;

endpackage

// File: hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit
	import isa_pkg::*, cpu_pkg::*;
(
	input  opcode_t      opcode,
	input  func_t        func_code,
	output logic         halt,
	output logic         wwd,
	output logic         new_inst,
	output logic         use_rs,
	output logic         use_rt,
	output logic         alu_src,
	output logic         branch,
	output logic         mem_read,
	output logic         mem_write,
	output logic         reg_write,
	output pc_src_t      pc_src,
	output reg_dest_t    reg_dest,
	output reg_src_t     reg_src,
	output branch_type_t alu_branch_type,
	output alu_func_t    alu_func_code
);

	always_comb begin
		halt = 1'b0;
		wwd = 1'b0;
		new_inst = 1'b1;    // cleared below for undefined encodings
		use_rs = 1'b0;
		use_rt = 1'b0;
		alu_src = 1'b0;
		branch = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		pc_src = PC_BRANCH;
		reg_dest = DEST_RD;
		reg_src = SRC_ALU;
		case (opcode)
			OP_ALU: begin
				case (func_code)
					FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR: begin
						use_rs = 1'b1;
						use_rt = 1'b1;
						reg_write = 1'b1;
					end
					FUNC_NOT, FUNC_TCP, FUNC_SHL, FUNC_SHR: begin
						use_rs = 1'b1;
						reg_write = 1'b1;
					end
					FUNC_JPR: begin
						use_rs = 1'b1;
						pc_src = PC_REG;
					end
					FUNC_JRL: begin
						use_rs = 1'b1;
						pc_src = PC_REG;
						reg_write = 1'b1;
						reg_dest = DEST_R2;
						reg_src = SRC_PC1;  // link is pc + 1
					end
					FUNC_WWD: begin
						use_rs = 1'b1;
						wwd = 1'b1;
					end
					FUNC_HLT: halt = 1'b1;
					default: new_inst = 1'b0;
				endcase
			end
			OP_ADI, OP_ORI: begin
				use_rs = 1'b1;      // rt is the destination here
				alu_src = 1'b1;
				reg_write = 1'b1;
				reg_dest = DEST_RT;
			end
			OP_LHI: begin
				use_rs = 1'b1;
				alu_src = 1'b1;
				reg_write = 1'b1;
				reg_dest = DEST_RT;
			end
			OP_LWD: begin
				use_rs = 1'b1;
				alu_src = 1'b1;
				mem_read = 1'b1;
				reg_write = 1'b1;
				reg_dest = DEST_RT;
				reg_src = SRC_MEM;
			end
			OP_SWD: begin
				use_rs = 1'b1;
				use_rt = 1'b1;      // store data
				alu_src = 1'b1;
				mem_write = 1'b1;
			end
			OP_BNE, OP_BEQ: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				branch = 1'b1;
			end
			OP_BGZ, OP_BLZ: begin
				use_rs = 1'b1;
				branch = 1'b1;
			end
			OP_JMP: pc_src = PC_JUMP;
			OP_JAL: begin
				pc_src = PC_JUMP;
				reg_write = 1'b1;
				reg_dest = DEST_R2;
				reg_src = SRC_PC1;
			end
			default: new_inst = 1'b0;
		endcase
	end

	// alu operation and branch condition
	always_comb begin
		alu_func_code = ALU_ID1;
		alu_branch_type = BR_NE;
		case (opcode)
			OP_ALU: begin
				if (func_code <= FUNC_SHR)
					alu_func_code = alu_func_t'(func_code[3:0]);
			end
			OP_ADI, OP_LWD, OP_SWD: alu_func_code = ALU_ADD;   // rs + imm
			OP_ORI: alu_func_code = ALU_ORR;
			OP_LHI: alu_func_code = ALU_ID2;
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
				alu_func_code = ALU_BXX;
				alu_branch_type = branch_type_t'(opcode[1:0]);
			end
			default: alu_func_code = ALU_ID1;
		endcase
	end

	// an undefined encoding must reach execute as a harmless bubble
	always_comb begin
		assert final (new_inst || !(reg_write || mem_read || mem_write || halt || wwd))
			else $error("control_unit: side effects on opcode %h func %h", opcode, func_code);
	end

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
	import isa_pkg::*;
(
	input  reg_idx_t id_rs,
	input  reg_idx_t id_rt,
	input  logic     use_rs,
	input  logic     use_rt,
	input  reg_idx_t ex_dest,
	input  logic     ex_writes,
	output logic     stall
);

	logic rs_hit;
	logic rt_hit;

	// no forwarding, wait until the producer is in writeback
	assign rs_hit = use_rs && (id_rs == ex_dest);
	assign rt_hit = use_rt && (id_rt == ex_dest);
	assign stall = ex_writes && (rs_hit || rt_hit);

	always_comb begin
		assert final (!stall || ex_writes)
			else $error("hazard_unit: stall without a writing instruction in execute");
	end

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
	import isa_pkg::*;
#(
	parameter word_t RESET_PC = '0
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  stall,
	input  logic  redirect,
	input  word_t redirect_pc,
	input  logic  freeze,
	output word_t i_addr,
	input  word_t i_data,
	output word_t if_inst,
	output word_t if_pc,
	output logic  if_valid
);

	word_t pc;
	logic running;  // low for the first cycle after reset

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (redirect)
				pc <= redirect_pc;  // wins over stall
			else if (running && !stall && !freeze)
				pc <= pc + 16'd1;
		end
	end

	assign i_addr = pc;
	assign if_inst = i_data;    // async instruction memory
	assign if_pc = pc;
	// squash the word being fetched on redirect or halt
	assign if_valid = running && !redirect && !freeze;

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
	import isa_pkg::*, cpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  word_t        if_inst,
	input  word_t        if_pc,
	input  logic         if_valid,
	input  logic         flush,
	input  logic         wb_write_en,
	input  reg_idx_t     wb_write_idx,
	input  word_t        wb_write_data,
	input  reg_idx_t     ex_dest,
	input  logic         ex_writes,
	output logic         stall,
	output logic         ex_valid,
	output logic         ex_halt,
	output logic         ex_wwd,
	output logic         ex_alu_src,
	output logic         ex_branch,
	output logic         ex_mem_read,
	output logic         ex_mem_write,
	output logic         ex_reg_write,
	output pc_src_t      ex_pc_src,
	output reg_src_t     ex_reg_src,
	output branch_type_t ex_branch_type,
	output alu_func_t    ex_alu_func,
	output word_t        ex_a,
	output word_t        ex_b,
	output word_t        ex_imm,
	output word_t        ex_pc,
	output reg_idx_t     ex_dest_idx
);

	word_t id_inst;
	word_t id_pc;
	logic id_valid;
	word_t regs [4];
	opcode_t id_opcode;
	reg_idx_t id_rs, id_rt, id_rd;
	word_t rs_val, rt_val, imm_ext;
	reg_idx_t dest_idx;
	logic halt, wwd, new_inst, use_rs, use_rt;
	logic alu_src, branch, mem_read, mem_write, reg_write;
	pc_src_t pc_src;
	reg_dest_t reg_dest;
	reg_src_t reg_src;
	branch_type_t branch_type;
	alu_func_t alu_func;

	assign id_opcode = id_inst[OP_MSB:OP_LSB];
	assign id_rs = id_inst[RS_MSB:RS_LSB];
	assign id_rt = id_inst[RT_MSB:RT_LSB];
	assign id_rd = id_inst[RD_MSB:RD_LSB];

	control_unit u_ctrl (
		.opcode(id_opcode), .func_code(id_inst[FUNC_W-1:0]),
		.halt(halt), .wwd(wwd), .new_inst(new_inst), .use_rs(use_rs), .use_rt(use_rt),
		.alu_src(alu_src), .branch(branch), .mem_read(mem_read), .mem_write(mem_write),
		.reg_write(reg_write), .pc_src(pc_src), .reg_dest(reg_dest), .reg_src(reg_src),
		.alu_branch_type(branch_type), .alu_func_code(alu_func)
	);

	hazard_unit u_hazard (
		.id_rs(id_rs), .id_rt(id_rt),
		.use_rs(use_rs && id_valid), .use_rt(use_rt && id_valid),
		.ex_dest(ex_dest), .ex_writes(ex_writes), .stall(stall)
	);

	// register file, writeback data visible in the same cycle
	always_ff @(posedge clk) begin
		if (reset)
			regs <= '{default: '0};
		else if (wb_write_en)
			regs[wb_write_idx] <= wb_write_data;
	end

	assign rs_val = (wb_write_en && wb_write_idx == id_rs) ? wb_write_data : regs[id_rs];
	assign rt_val = (wb_write_en && wb_write_idx == id_rt) ? wb_write_data : regs[id_rt];

	always_comb begin
		case (id_opcode)
			OP_ORI: imm_ext = {8'h00, id_inst[IMM_W-1:0]};
			OP_LHI: imm_ext = {id_inst[IMM_W-1:0], 8'h00};  // already shifted
			OP_JMP, OP_JAL: imm_ext = {4'h0, id_inst[TGT_W-1:0]};
			default: imm_ext = {{8{id_inst[IMM_W-1]}}, id_inst[IMM_W-1:0]};
		endcase
		case (reg_dest)
			DEST_RT: dest_idx = id_rt;
			DEST_R2: dest_idx = 2'd2;
			default: dest_idx = id_rd;
		endcase
	end

	// fetch/decode register, held on stall
	always_ff @(posedge clk) begin
		if (reset || flush)
			id_valid <= 1'b0;
		else if (!stall)
			id_valid <= if_valid;
		if (!stall) begin
			id_inst <= if_inst;
			id_pc <= if_pc;
		end
	end

	// decode/execute register, bubble on stall
	always_ff @(posedge clk) begin
		if (reset || flush || stall)
			ex_valid <= 1'b0;
		else
			ex_valid <= id_valid && new_inst;
		ex_halt <= halt;
		ex_wwd <= wwd;
		ex_alu_src <= alu_src;
		ex_branch <= branch;
		ex_mem_read <= mem_read;
		ex_mem_write <= mem_write;
		ex_reg_write <= reg_write;
		ex_pc_src <= pc_src;
		ex_reg_src <= reg_src;
		ex_branch_type <= branch_type;
		ex_alu_func <= alu_func;
		ex_a <= rs_val;
		ex_b <= rt_val;
		ex_imm <= imm_ext;
		ex_pc <= id_pc;
		ex_dest_idx <= dest_idx;
	end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
	import isa_pkg::*, cpu_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         ex_valid,
	input  logic         ex_halt,
	input  logic         ex_wwd,
	input  logic         ex_alu_src,
	input  logic         ex_branch,
	input  logic         ex_mem_read,
	input  logic         ex_mem_write,
	input  logic         ex_reg_write,
	input  pc_src_t      ex_pc_src,
	input  reg_src_t     ex_reg_src,
	input  branch_type_t ex_branch_type,
	input  alu_func_t    ex_alu_func,
	input  word_t        ex_a,
	input  word_t        ex_b,
	input  word_t        ex_imm,
	input  word_t        ex_pc,
	input  reg_idx_t     ex_dest_idx,
	output word_t        d_addr,
	output logic         d_read,
	output logic         d_write,
	output word_t        d_wdata,
	input  word_t        d_rdata,
	output logic         redirect,
	output word_t        redirect_pc,
	output logic         freeze,
	output logic         flush,
	output logic         wb_write_en,
	output reg_idx_t     wb_write_idx,
	output word_t        wb_write_data,
	output reg_idx_t     ex_dest,
	output logic         ex_writes,
	output word_t        output_port,
	output logic         wwd,
	output logic         halt,
	output word_t        num_inst
);

	word_t alu_b, alu_result, pc_plus1;
	logic taken, is_jump, hlt_now;
	logic wb_valid, wb_wwd, wb_reg_write;
	reg_src_t wb_reg_src;
	reg_idx_t wb_dest;
	word_t wb_result, wb_pc1;

	assign alu_b = ex_alu_src ? ex_imm : ex_b;
	assign pc_plus1 = ex_pc + 16'd1;

	always_comb begin
		case (ex_alu_func)
			ALU_ADD: alu_result = ex_a + alu_b;
			ALU_SUB, ALU_BXX: alu_result = ex_a - alu_b;
			ALU_AND: alu_result = ex_a & alu_b;
			ALU_ORR: alu_result = ex_a | alu_b;
			ALU_NOT: alu_result = ~ex_a;
			ALU_TCP: alu_result = ~ex_a + 16'd1;
			ALU_SHL: alu_result = {ex_a[14:0], 1'b0};
			ALU_SHR: alu_result = {ex_a[15], ex_a[15:1]};  // arithmetic
			ALU_ID1: alu_result = ex_a;
			ALU_ID2: alu_result = alu_b;
			default: alu_result = '0;
		endcase
		case (ex_branch_type)
			BR_NE: taken = (alu_result != '0);
			BR_EQ: taken = (alu_result == '0);
			BR_GZ: taken = !ex_a[15] && (ex_a != '0);
			BR_LZ: taken = ex_a[15];
			default: taken = 1'b0;
		endcase
		case (ex_pc_src)
			PC_JUMP: redirect_pc = {ex_pc[15:TGT_W], ex_imm[TGT_W-1:0]};
			PC_REG: redirect_pc = ex_a;
			default: redirect_pc = pc_plus1 + ex_imm;
		endcase
	end

	assign is_jump = (ex_pc_src != PC_BRANCH);
	assign redirect = ex_valid && ((ex_branch && taken) || is_jump);
	assign hlt_now = ex_valid && ex_halt;
	assign freeze = hlt_now || halt;    // pc stays put from here on
	assign flush = redirect || hlt_now;

	assign d_addr = alu_result;
	assign d_read = ex_valid && ex_mem_read;
	assign d_write = ex_valid && ex_mem_write;
	assign d_wdata = ex_b;

	assign ex_dest = ex_dest_idx;
	assign ex_writes = ex_valid && ex_reg_write;

	// writeback register
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			halt <= 1'b0;
			output_port <= '0;
			num_inst <= '0;
		end else begin
			wb_valid <= ex_valid;
			if (hlt_now)
				halt <= 1'b1;   // sticky until reset
			if (ex_valid && ex_wwd)
				output_port <= ex_a;
			if (ex_valid)
				num_inst <= num_inst + 16'd1;
		end
		wb_wwd <= ex_wwd;
		wb_reg_write <= ex_reg_write;
		wb_reg_src <= ex_reg_src;
		wb_dest <= ex_dest_idx;
		wb_result <= alu_result;
		wb_pc1 <= pc_plus1;
	end

	assign wwd = wb_valid && wb_wwd;
	assign wb_write_en = wb_valid && wb_reg_write;
	assign wb_write_idx = wb_dest;

	always_comb begin
		case (wb_reg_src)
			SRC_MEM: wb_write_data = d_rdata;   // load data arrives now
			SRC_PC1: wb_write_data = wb_pc1;
			default: wb_write_data = wb_result;
		endcase
	end

	assert property (@(posedge clk) disable iff (reset) !(d_read && d_write))
		else $error("execute_stage: read and write to data memory together");

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
	import isa_pkg::*, cpu_pkg::*;
#(
	parameter word_t RESET_PC = '0
) (
	input  logic  clk,
	input  logic  reset,
	output word_t i_addr,
	input  word_t i_data,
	output word_t d_addr,
	output logic  d_read,
	output logic  d_write,
	output word_t d_wdata,
	input  word_t d_rdata,
	output word_t output_port,
	output logic  wwd,
	output logic  halt,
	output word_t num_inst
);

	// fetch and decode
	word_t if_inst, if_pc;
	logic if_valid, stall;
	// execute back to the front end
	logic redirect, freeze, flush;
	word_t redirect_pc;
	logic wb_write_en, ex_writes;
	reg_idx_t wb_write_idx, ex_dest;
	word_t wb_write_data;
	// decode/execute register
	logic ex_valid, ex_halt, ex_wwd, ex_alu_src, ex_branch;
	logic ex_mem_read, ex_mem_write, ex_reg_write;
	pc_src_t ex_pc_src;
	reg_src_t ex_reg_src;
	branch_type_t ex_branch_type;
	alu_func_t ex_alu_func;
	word_t ex_a, ex_b, ex_imm, ex_pc;
	reg_idx_t ex_dest_idx;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (.*);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

endmodule

// File: tests/cpu_core_tests.svh
`ifndef CPU_CORE_TESTS_SVH
`define CPU_CORE_TESTS_SVH

localparam int NUM_TESTS = 6;
localparam int PROG_LEN = 16;
localparam int RAND_TEST = 5;   // filled at run time
localparam word_t HLT_INST = {OP_ALU, 6'd0, FUNC_HLT};

string test_name [NUM_TESTS];
word_t test_prog [NUM_TESTS][PROG_LEN];
word_t test_data [NUM_TESTS][4];
word_t test_outs [NUM_TESTS][4];  // wwd values in order
int test_nout [NUM_TESTS];
int test_retired [NUM_TESTS];

// rd = rs op rt
function automatic word_t alu_word(input reg_idx_t rs, input reg_idx_t rt,
		input reg_idx_t rd, input func_t fn);
	return {OP_ALU, rs, rt, rd, fn};
endfunction

function automatic word_t imm_word(input opcode_t op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [7:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic word_t jump_word(input opcode_t op, input logic [11:0] target);
	return {op, target};
endfunction

task automatic build_table();
	// dependent chain, r1 = 1234, r2 = 1230, r3 = 2464 then 1230
	test_name[0] = "alu_chain";
	test_prog[0] = '{
		imm_word(OP_LHI, 2'd0, 2'd1, 8'h12), imm_word(OP_ORI, 2'd1, 2'd1, 8'h34),
		imm_word(OP_ADI, 2'd1, 2'd2, 8'hfc), alu_word(2'd1, 2'd2, 2'd3, FUNC_ADD),
		alu_word(2'd3, 2'd1, 2'd3, FUNC_SUB), alu_word(2'd3, 2'd1, 2'd0, FUNC_AND),
		alu_word(2'd0, 2'd1, 2'd0, FUNC_ORR), alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD),
		alu_word(2'd1, 2'd0, 2'd3, FUNC_NOT), alu_word(2'd3, 2'd0, 2'd3, FUNC_TCP),
		alu_word(2'd3, 2'd0, 2'd3, FUNC_SHL), alu_word(2'd3, 2'd0, 2'd0, FUNC_WWD),
		alu_word(2'd3, 2'd0, 2'd0, FUNC_NOT), alu_word(2'd0, 2'd0, 2'd0, FUNC_SHR),
		alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD), HLT_INST
	};
	test_data[0] = '{16'h0, 16'h0, 16'h0, 16'h0};
	test_outs[0] = '{16'h1234, 16'h246a, 16'hedca, 16'h0};   // ~246a >> 1 keeps sign
	test_nout[0] = 3;
	test_retired[0] = 16;

	test_name[1] = "load_store";
	test_prog[1] = '{
		imm_word(OP_LWD, 2'd0, 2'd1, 8'h02), alu_word(2'd1, 2'd0, 2'd0, FUNC_WWD),
		imm_word(OP_LHI, 2'd0, 2'd2, 8'hbe), imm_word(OP_ORI, 2'd2, 2'd2, 8'hef),
		imm_word(OP_SWD, 2'd0, 2'd2, 8'h01), imm_word(OP_LWD, 2'd0, 2'd3, 8'h01),
		alu_word(2'd3, 2'd1, 2'd0, FUNC_ADD), alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD),
		alu_word(2'd3, 2'd0, 2'd0, FUNC_WWD), HLT_INST, HLT_INST, HLT_INST,
		HLT_INST, HLT_INST, HLT_INST, HLT_INST
	};
	test_data[1] = '{16'h1111, 16'h2222, 16'h3333, 16'h4444};
	test_outs[1] = '{16'h3333, 16'hf222, 16'hbeef, 16'h0};
	test_nout[1] = 3;
	test_retired[1] = 10;

	// r1 = 5, r2 = -3, every skipped slot is a wwd
	test_name[2] = "branches";
	test_prog[2] = '{
		imm_word(OP_ADI, 2'd0, 2'd1, 8'h05), imm_word(OP_ADI, 2'd0, 2'd2, 8'hfd),
		imm_word(OP_BNE, 2'd1, 2'd0, 8'h01), alu_word(2'd2, 2'd0, 2'd0, FUNC_WWD),
		imm_word(OP_BNE, 2'd0, 2'd0, 8'h01), alu_word(2'd1, 2'd0, 2'd0, FUNC_WWD),
		imm_word(OP_BEQ, 2'd0, 2'd0, 8'h01), alu_word(2'd2, 2'd0, 2'd0, FUNC_WWD),
		imm_word(OP_BEQ, 2'd1, 2'd0, 8'h01), imm_word(OP_BGZ, 2'd1, 2'd0, 8'h01),
		alu_word(2'd2, 2'd0, 2'd0, FUNC_WWD), imm_word(OP_BGZ, 2'd2, 2'd0, 8'h01),
		imm_word(OP_BLZ, 2'd0, 2'd0, 8'h01), imm_word(OP_BLZ, 2'd2, 2'd0, 8'h01),
		alu_word(2'd1, 2'd0, 2'd0, FUNC_WWD), HLT_INST
	};
	test_data[2] = '{16'h0, 16'h0, 16'h0, 16'h0};
	test_outs[2] = '{16'h0005, 16'h0, 16'h0, 16'h0};
	test_nout[2] = 1;
	test_retired[2] = 12;

	test_name[3] = "jumps";
	test_prog[3] = '{
		jump_word(OP_JMP, 12'd2), alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD),
		jump_word(OP_JAL, 12'd5), alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD),
		alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD), alu_word(2'd2, 2'd0, 2'd0, FUNC_WWD),
		imm_word(OP_ADI, 2'd0, 2'd1, 8'd10), alu_word(2'd1, 2'd0, 2'd0, FUNC_JRL),
		alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD), alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD),
		alu_word(2'd2, 2'd0, 2'd0, FUNC_WWD), imm_word(OP_ADI, 2'd0, 2'd3, 8'd14),
		alu_word(2'd3, 2'd0, 2'd0, FUNC_JPR), alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD),
		alu_word(2'd3, 2'd0, 2'd0, FUNC_WWD), HLT_INST
	};
	test_data[3] = '{16'h0, 16'h0, 16'h0, 16'h0};
	test_outs[3] = '{16'h0003, 16'h0008, 16'h000e, 16'h0};   // link values, then target
	test_nout[3] = 3;
	test_retired[3] = 10;

	test_name[4] = "halt";
	test_prog[4] = '{
		imm_word(OP_ADI, 2'd0, 2'd1, 8'h07), alu_word(2'd1, 2'd0, 2'd0, FUNC_WWD),
		HLT_INST, alu_word(2'd1, 2'd0, 2'd0, FUNC_WWD),
		alu_word(2'd1, 2'd0, 2'd0, FUNC_WWD), HLT_INST, HLT_INST, HLT_INST,
		HLT_INST, HLT_INST, HLT_INST, HLT_INST, HLT_INST, HLT_INST, HLT_INST, HLT_INST
	};
	test_data[4] = '{16'h0, 16'h0, 16'h0, 16'h0};
	test_outs[4] = '{16'h0007, 16'h0, 16'h0, 16'h0};
	test_nout[4] = 1;
	test_retired[4] = 3;
endtask

`endif

// File: tests/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb
	import isa_pkg::*;
();

	`include "cpu_core_tests.svh"

	localparam int CYCLE_LIMIT = NUM_TESTS * (16 * 4 + 20);

	logic clk;
	logic reset;
	word_t i_addr, i_data, d_addr, d_wdata, output_port, num_inst;
	word_t d_rdata = '0;
	logic d_read, d_write, wwd, halt;

	word_t imem [64];
	word_t dmem [256];
	word_t seen [$];    // wwd values of the running test
	int cycles;
	int errors;
	int passed;

	cpu_core #(.RESET_PC(16'h0000)) DUT (
		.clk(clk), .reset(reset), .i_addr(i_addr), .i_data(i_data),
		.d_addr(d_addr), .d_read(d_read), .d_write(d_write), .d_wdata(d_wdata),
		.d_rdata(d_rdata), .output_port(output_port), .wwd(wwd), .halt(halt),
		.num_inst(num_inst)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	assign i_data = imem[i_addr[5:0]];  // async read

	always @(posedge clk) begin
		if (d_write)
			dmem[d_addr[7:0]] <= d_wdata;
		if (d_read)
			d_rdata <= dmem[d_addr[7:0]];   // valid one cycle later
	end

	always @(negedge clk) begin
		if (!reset && wwd)
			seen.push_back(output_port);
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles without finishing all tests", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic word_t sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	task automatic make_random_chain();
		logic [7:0] imm [4];
		word_t r0, r1, r2, r3;
		for (int k = 0; k < 4; k++)
			imm[k] = 8'($urandom);
		test_name[RAND_TEST] = "random_chain";
		test_prog[RAND_TEST] = '{
			imm_word(OP_ADI, 2'd0, 2'd1, imm[0]), imm_word(OP_ADI, 2'd1, 2'd2, imm[1]),
			alu_word(2'd1, 2'd2, 2'd3, FUNC_ADD), imm_word(OP_ADI, 2'd3, 2'd3, imm[2]),
			alu_word(2'd3, 2'd2, 2'd0, FUNC_ADD), alu_word(2'd0, 2'd0, 2'd0, FUNC_WWD),
			imm_word(OP_ADI, 2'd0, 2'd1, imm[3]), alu_word(2'd1, 2'd0, 2'd0, FUNC_WWD),
			HLT_INST, HLT_INST, HLT_INST, HLT_INST, HLT_INST, HLT_INST, HLT_INST, HLT_INST
		};
		// registers start at zero after reset
		r1 = sext8(imm[0]);
		r2 = r1 + sext8(imm[1]);
		r3 = r1 + r2;
		r3 = r3 + sext8(imm[2]);
		r0 = r3 + r2;
		r1 = r0 + sext8(imm[3]);
		test_data[RAND_TEST] = '{16'h0, 16'h0, 16'h0, 16'h0};
		test_outs[RAND_TEST] = '{r0, r1, 16'h0, 16'h0};
		test_nout[RAND_TEST] = 2;
		test_retired[RAND_TEST] = 9;
	endtask

	task automatic load_test(input int t);
		for (int a = 0; a < 64; a++)
			imem[a] = (a < PROG_LEN) ? test_prog[t][a] : {OP_ALU, 6'(a), FUNC_HLT};
		for (int a = 0; a < 256; a++)
			dmem[a] <= (a < 4) ? test_data[t][a] : {~8'(a), 8'(a)};
	endtask

	task automatic check_results(input int t);
		assert (seen.size() == test_nout[t])
			else begin
				$display("mismatch at %0t: %s wwd count %0d, expected %0d",
					$time, test_name[t], seen.size(), test_nout[t]);
				errors++;
			end
		for (int k = 0; k < test_nout[t] && k < seen.size(); k++) begin
			assert (seen[k] == test_outs[t][k])
				else begin
					$display("mismatch at %0t: %s wwd %0d is %h, expected %h",
						$time, test_name[t], k, seen[k], test_outs[t][k]);
					errors++;
				end
		end
		assert (num_inst == 16'(test_retired[t]))
			else begin
				$display("mismatch at %0t: %s num_inst %0d, expected %0d",
					$time, test_name[t], num_inst, test_retired[t]);
				errors++;
			end
	endtask

	task automatic run_test(input int t);
		int errors_before;
		errors_before = errors;
		@(negedge clk);
		reset = 1'b1;
		seen.delete();
		load_test(t);
		repeat (10) @(negedge clk);
		assert (num_inst == 16'd0 && !halt && !wwd && i_addr == 16'h0000
				&& output_port == 16'h0000 && !d_read && !d_write)
			else begin
				$display("%s: status outputs not cleared by reset", test_name[t]);
				errors++;
			end
		reset = 1'b0;
		while (!halt)
			@(negedge clk);
		// halt must hold and nothing may retire afterwards
		repeat (8) begin
			@(negedge clk);
			assert (halt)
				else begin
					$display("%s: halt dropped after it was raised", test_name[t]);
					errors++;
				end
		end
		check_results(t);
		if (errors == errors_before) begin
			passed++;
			$display("PASS %s", test_name[t]);
		end else begin
			$display("FAIL %s", test_name[t]);
		end
	endtask

	initial begin
		reset = 1'b1;
		errors = 0;
		passed = 0;
		void'($urandom(32'h89ed_12ea));
		build_table();
		make_random_chain();
		load_test(0);
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("%0d of %0d tests passed, %0d failed checks", passed, NUM_TESTS, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: cpu_core.f
+incdir+tests
hdl/isa_pkg.sv
hdl/cpu_pkg.sv
hdl/control_unit.sv
hdl/hazard_unit.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/cpu_core.sv
tests/cpu_core_tb.sv
